// File: design/lsu_pkg.sv
////////////////////
// widths and encodings shared by the load/store unit
// the data path is fixed at 32 bits with four byte lanes
// size codes 2'b10 and 2'b11 both select a byte access
////////////////////
package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned DataW = 32;        // bus and register word
  localparam int unsigned BeW   = DataW / 8; // one enable per byte lane

  ////////////////////
  // access size
  ////////////////////

  // encoding follows the execute stage, byte has two codes
  typedef enum logic [1:0] {
    LSU_WORD   = 2'b00,
    LSU_HALF   = 2'b01,
    LSU_BYTE   = 2'b10,
    LSU_BYTE_X = 2'b11 // alternate byte code
  } lsu_type_e;

  // byte position inside a bus word
  typedef logic [1:0] lsu_offset_t;

  ////////////////////
  // bus word views
  ////////////////////

  // one bus word, read either lane by lane or half by half
  // b[0] and h[0] are the low end of the word
  typedef union packed {
    logic [BeW-1:0][7:0] b; // byte lanes
    logic [1:0][15:0]    h; // half words
  } lsu_word_u;

endpackage

// File: design/lsu_store_align.sv
////////////////////
// byte enables and store data lanes for one bus access
// purely combinational, the offset must be the one of the first part
// also while the second part of a split is on the bus
////////////////////
`timescale 1ns/100ps

module lsu_store_align (
  input  lsu_pkg::lsu_offset_t      addr_offset_i, // byte offset of the access
  input  lsu_pkg::lsu_type_e        lsu_type_i,    // word, half or byte
  input  logic                      second_part_i, // second bus access of a split
  input  logic [lsu_pkg::DataW-1:0] lsu_wdata_i,   // store data, lsb aligned
  output logic [lsu_pkg::BeW-1:0]   data_be_o,
  output logic [lsu_pkg::DataW-1:0] data_wdata_o
);

  import lsu_pkg::*;

  logic [BeW-1:0]   size_mask; // lanes touched when the offset is zero
  logic [2*BeW-1:0] lane_span; // same lanes moved to the offset, over two words

  ////////////////////
  // byte enables
  ////////////////////

  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD: size_mask = 4'b1111;
      LSU_HALF: size_mask = 4'b0011;
      default:  size_mask = 4'b0001; // both byte codes
    endcase
  end

  // shifting into a double word puts the spill of a misaligned access
  // in the upper half, which is exactly the low lanes of the next word
  //   word off 1  -> 1110 then 0001
  //   word off 3  -> 1000 then 0111
  //   half off 3  -> 1000 then 0001
  assign lane_span = {{BeW{1'b0}}, size_mask} << addr_offset_i;

  // first part takes the lower word, second part the leftover lanes
  assign data_be_o = second_part_i ? lane_span[2*BeW-1:BeW] : lane_span[BeW-1:0];

  ////////////////////
  // store data
  ////////////////////

  // rotate left by the offset so byte 0 lands in its lane
  // bytes that wrap around end up in the low lanes, ready for part two
  always_comb begin
    unique case (addr_offset_i)
      2'd0: data_wdata_o = lsu_wdata_i;
      2'd1: data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'd2: data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      2'd3: data_wdata_o = {lsu_wdata_i[7:0], lsu_wdata_i[31:8]};
      default: begin
        data_wdata_o = lsu_wdata_i;
      end
    endcase
  end

endmodule

// File: design/lsu_load_align.sv
////////////////////
// load data assembly from one or two bus words
// result is valid in the rvalid cycle of the last bus word
// the offset is taken on the first grant and must not change after it
////////////////////
`timescale 1ns/100ps

module lsu_load_align (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ctrl_update_i,  // capture size, offset, sign
  input  logic                      rdata_update_i, // capture first bus word
  input  lsu_pkg::lsu_offset_t      addr_offset_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [lsu_pkg::DataW-1:0] data_rdata_i,
  output logic [lsu_pkg::DataW-1:0] lsu_rdata_o
);

  import lsu_pkg::*;

  lsu_offset_t      offset_q;   // offset of the access in flight
  lsu_type_e        type_q;     // size of the access in flight
  logic             sign_ext_q;
  logic [DataW-1:8] rdata_q;    // upper three bytes of the first word

  lsu_word_u        cur_w;      // word on the bus this cycle
  lsu_word_u        prev_w;     // captured first word of a split
  logic [DataW-1:0] word_rdata;
  logic [15:0]      half_rdata;
  logic [7:0]       byte_rdata;

  ////////////////////
  // access registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= addr_offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // byte 0 of the first word never reaches the result
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[DataW-1:8];
    end
  end

  assign cur_w  = data_rdata_i;
  assign prev_w = {rdata_q, 8'h00};

  ////////////////////
  // realignment
  ////////////////////

  // low bytes come from the first word, high bytes from the second
  always_comb begin
    unique case (offset_q)
      2'd1:    word_rdata = {cur_w.b[0], prev_w.b[3], prev_w.b[2], prev_w.b[1]};
      2'd2:    word_rdata = {cur_w.h[0], prev_w.h[1]};
      2'd3:    word_rdata = {cur_w.b[2], cur_w.b[1], cur_w.b[0], prev_w.b[3]};
      default: word_rdata = cur_w; // aligned, single access
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'd0:    half_rdata = cur_w.h[0];
      2'd1:    half_rdata = {cur_w.b[2], cur_w.b[1]};
      2'd2:    half_rdata = cur_w.h[1];
      default: half_rdata = {cur_w.b[0], prev_w.b[3]}; // spans two words
    endcase
  end

  assign byte_rdata = cur_w.b[offset_q]; // a byte never splits

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    unique case (type_q)
      LSU_WORD: lsu_rdata_o = word_rdata;
      LSU_HALF: lsu_rdata_o = {{16{sign_ext_q & half_rdata[15]}}, half_rdata};
      default:  lsu_rdata_o = {{24{sign_ext_q & byte_rdata[7]}}, byte_rdata};
    endcase
  end

endmodule

// File: design/lsu_ctrl_fsm.sv
////////////////////
// transaction control of the load/store unit
// at most two bus accesses are outstanding, responses return in order
// while addr_incr_req_o is high addr_i must hold the aligned address plus 4
////////////////////
`timescale 1ns/100ps

module lsu_ctrl_fsm #(
  parameter int unsigned AddrW = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  lsu_pkg::lsu_type_e   lsu_type_i,
  input  logic [AddrW-1:0]     addr_i,         // computed address from execute
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  output logic                 data_req_o,
  output logic [AddrW-1:0]     data_addr_o,
  output logic                 data_we_o,
  output lsu_pkg::lsu_offset_t addr_offset_o,  // offset for the lane logic
  output logic                 second_part_o,
  output logic                 ctrl_update_o,
  output logic                 rdata_update_o,
  output logic                 addr_incr_req_o,
  output logic [AddrW-1:0]     addr_last_o,    // for trap reporting
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic                 busy_o
);

  import lsu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,             // no grant pending
    WAIT_GNT_MIS,     // split, first grant pending
    WAIT_RVALID_MIS,  // split, second request out, first rvalid pending
    WAIT_GNT,         // single grant pending, either unsplit or second part
    WAIT_RVALID_DONE  // both grants seen, first rvalid pending
  } ls_state_e;

  ls_state_e        state_q, state_d;
  lsu_offset_t      data_offset;
  lsu_offset_t      offset_q;         // first part offset, held over the split
  logic             split_access;
  logic             second_part_q, second_part_d;
  logic             err_q, err_d;     // error seen on the first part
  logic             we_q;             // direction of the access in flight
  logic             addr_update;
  logic [AddrW-1:0] addr_aligned;
  logic [AddrW-1:0] addr_last_q;
  logic             resp_err;

  assign data_offset  = addr_i[1:0];
  assign addr_aligned = {addr_i[AddrW-1:2], 2'b00};

  // misaligned word, or half word that crosses the word boundary
  assign split_access = ((lsu_type_i == LSU_WORD) && (data_offset != 2'd0)) ||
                        ((lsu_type_i == LSU_HALF) && (data_offset == 2'd3));

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d         = state_q;
    second_part_d   = second_part_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;
    addr_update     = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            second_part_d = split_access;
            state_d       = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            state_d       = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end
      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          second_part_d = 1'b1;
          state_d       = WAIT_RVALID_MIS;
        end
      end
      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1; // second part goes out right away
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          addr_update    = data_gnt_i & ~data_err_i; // keep a failing first address
          second_part_d  = ~data_gnt_i;
          state_d        = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          second_part_d = 1'b0;
          state_d       = WAIT_RVALID_DONE;
        end
      end
      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_part_q;
        if (data_gnt_i) begin
          ctrl_update_o = ~second_part_q; // second part keeps the first offset
          addr_update   = ~err_q;
          second_part_d = 1'b0;
          state_d       = IDLE;
        end
      end
      WAIT_RVALID_DONE: begin
        addr_incr_req_o = 1'b1; // second address still needed for addr_last
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;
          addr_update    = ~data_err_i;
          state_d        = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      second_part_q <= 1'b0;
      err_q         <= 1'b0;
      we_q          <= 1'b0;
      offset_q      <= '0;
      addr_last_q   <= '0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      err_q         <= err_d;
      if (ctrl_update_o) begin
        we_q     <= lsu_we_i;
        offset_q <= data_offset;
      end
      if (addr_update) begin
        // second part records its aligned word, first part the exact address
        addr_last_q <= addr_incr_req_o ? addr_aligned : addr_i;
      end
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  assign data_addr_o   = addr_aligned;
  assign data_we_o     = lsu_we_i;
  assign second_part_o = second_part_q;
  assign addr_offset_o = second_part_q ? offset_q : data_offset;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (state_q != IDLE);

  // last rvalid of an access always lands in IDLE
  assign resp_err          = err_q | data_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & resp_err & we_q;

endmodule

// File: design/lsu_top.sv
////////////////////
// load/store unit, execute side to req/gnt/rvalid data bus
// one request at a time, inputs held until lsu_resp_valid_o
// word and offset-3 half accesses go out as two aligned bus words
////////////////////
`timescale 1ns/100ps

module lsu_top #(
  parameter int unsigned AddrW = 32
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // execute stage
  input  logic                      lsu_req_i,         // single-cycle request
  input  logic                      lsu_we_i,
  input  lsu_pkg::lsu_type_e        lsu_type_i,
  input  logic [lsu_pkg::DataW-1:0] lsu_wdata_i,
  input  logic                      lsu_sign_ext_i,
  input  logic [AddrW-1:0]          addr_i,
  output logic [lsu_pkg::DataW-1:0] lsu_rdata_o,
  output logic                      lsu_rdata_valid_o,
  output logic                      lsu_resp_valid_o,  // end of the access
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      addr_incr_req_o,   // present next word address
  output logic [AddrW-1:0]          addr_last_o,
  output logic                      busy_o,

  // data bus
  output logic                      data_req_o,
  output logic [AddrW-1:0]          data_addr_o,       // always word aligned
  output logic                      data_we_o,
  output logic [lsu_pkg::BeW-1:0]   data_be_o,
  output logic [lsu_pkg::DataW-1:0] data_wdata_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [lsu_pkg::DataW-1:0] data_rdata_i,
  input  logic                      data_err_i
);

  import lsu_pkg::*;

  lsu_offset_t lane_offset;  // held across a split by the FSM
  logic        second_part;
  logic        ctrl_update;
  logic        rdata_update;

  lsu_ctrl_fsm #(
    .AddrW (AddrW)
  ) u_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .addr_i            (addr_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .data_req_o        (data_req_o),
    .data_addr_o       (data_addr_o),
    .data_we_o         (data_we_o),
    .addr_offset_o     (lane_offset),
    .second_part_o     (second_part),
    .ctrl_update_o     (ctrl_update),
    .rdata_update_o    (rdata_update),
    .addr_incr_req_o   (addr_incr_req_o),
    .addr_last_o       (addr_last_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  lsu_store_align u_store_align (
    .addr_offset_i (lane_offset),
    .lsu_type_i    (lsu_type_i),
    .second_part_i (second_part),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  // offset only sampled on a first-part grant, so addr_i is safe here
  lsu_load_align u_load_align (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .addr_offset_i  (addr_i[1:0]),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

endmodule

// File: bench/lsu_mem_slave.sv
////////////////////
// data bus responder, 64 words, in-order responses
// grant 0 to 2 cycles late, rvalid 1 to 3 cycles after the grant
// words with address bits [7:6] == 3 answer with an error and ignore writes
////////////////////
`timescale 1ns/100ps

module lsu_mem_slave #(
  parameter logic [31:0] Seed = 32'h42b7
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic        data_we_i,
  input  logic [3:0]  data_be_i,
  input  logic [31:0] data_wdata_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o,
  output logic        data_err_o
);

  logic [31:0] mem [64];
  logic [31:0] rnd;
  int          wait_cnt, gnt_delay;   // cycles the current request has waited
  int          cyc, last_due, due, idx;
  int          q_due[$];              // pending responses, oldest first
  logic [31:0] q_data[$];
  logic        q_err[$];

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fill pattern depends on the whole word index
  function automatic logic [31:0] fill_word(input int i);
    return (i * 32'h0101_0107) ^ 32'h5a3c_0f96;
  endfunction

  initial begin
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
  end

  assign data_gnt_o = data_req_i && (wait_cnt >= gnt_delay);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rnd           = Seed;
      cyc           = 0;
      last_due      = 0;
      q_due.delete();
      q_data.delete();
      q_err.delete();
      wait_cnt      <= 0;
      gnt_delay     <= 0;
      data_rvalid_o <= 1'b0;
      data_rdata_o  <= '0;
      data_err_o    <= 1'b0;
    end else begin
      rnd = lcg_next(rnd);
      if (data_req_i && data_gnt_o) begin
        idx = int'(data_addr_i[7:2]);
        if (data_we_i && data_addr_i[7:6] != 2'b11) begin
          for (int b = 0; b < 4; b++)
            if (data_be_i[b]) mem[idx][8*b +: 8] = data_wdata_i[8*b +: 8];
        end
        due = cyc + 1 + int'(rnd[9:8] % 2'd3);
        if (due <= last_due) due = last_due + 1; // keep responses in order
        last_due = due;
        q_due.push_back(due);
        q_data.push_back(mem[idx]);
        q_err.push_back(data_addr_i[7:6] == 2'b11);
        wait_cnt  <= 0;
        gnt_delay <= int'(rnd[17:16] % 2'd3);
      end else if (data_req_i) begin
        wait_cnt <= wait_cnt + 1;
      end
      cyc = cyc + 1;
      if (q_due.size() > 0 && q_due[0] <= cyc) begin
        data_rvalid_o <= 1'b1;
        data_err_o    <= q_err[0];
        data_rdata_o  <= q_err[0] ? 32'h0 : q_data[0];
        void'(q_due.pop_front());
        void'(q_data.pop_front());
        void'(q_err.pop_front());
      end else begin
        data_rvalid_o <= 1'b0;
        data_err_o    <= 1'b0;
      end
    end
  end

endmodule

// File: bench/lsu_tb.sv
////////////////////
// random load/store run against a byte model of the bus memory
// the bench plays the execute stage, including the plus-4 address
////////////////////
`timescale 1ns/100ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int NumOps  = 400;
  localparam int Timeout = NumOps * 40 + 20;

  logic clk_i, rst_ni;
  logic lsu_req, lsu_we, sign_ext, rdata_valid, resp_valid;
  logic load_err, store_err, incr_req, busy;
  logic data_req, data_we, data_gnt, data_rvalid, data_err;
  lsu_type_e   lsu_type;
  logic [31:0] wdata, addr, rdata, addr_last, data_addr, data_wdata, data_rdata;
  logic [3:0]  data_be;

  logic [7:0]  model [256];       // byte image of the bus memory
  logic [31:0] seed;
  int          cycles, gnt_total, rv_total;
  logic [31:0] gnt_addr [1024];   // grant log, indexed by grant count
  logic [3:0]  gnt_be [1024];
  logic        gnt_we [1024];
  logic [31:0] gnt_wdata [1024];

  lsu_top #(.AddrW(32)) u_dut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .lsu_req_i (lsu_req), .lsu_we_i (lsu_we), .lsu_type_i (lsu_type),
    .lsu_wdata_i (wdata), .lsu_sign_ext_i (sign_ext), .addr_i (addr),
    .lsu_rdata_o (rdata), .lsu_rdata_valid_o (rdata_valid),
    .lsu_resp_valid_o (resp_valid), .load_err_o (load_err), .store_err_o (store_err),
    .addr_incr_req_o (incr_req), .addr_last_o (addr_last), .busy_o (busy),
    .data_req_o (data_req), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_gnt_i (data_gnt),
    .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata), .data_err_i (data_err)
  );

  lsu_mem_slave #(.Seed(32'h42b7 ^ 32'h1357)) u_mem (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .data_req_i (data_req), .data_addr_i (data_addr), .data_we_i (data_we),
    .data_be_i (data_be), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
    .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata), .data_err_o (data_err)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // lanes hit by bytes off .. off+n-1, part 1 sees the spill into the next word
  function automatic logic [3:0] expect_be(input int off, input int n, input int part);
    logic [3:0] be;
    for (int j = 0; j < 4; j++) be[j] = (j + 4 * part >= off) && (j + 4 * part < off + n);
    return be;
  endfunction

  // store byte k sits in lane off+k, counted over both parts
  function automatic logic [31:0] expect_lanes(input logic [31:0] d, input int off,
                                               input int n, input int part);
    logic [31:0] w;
    int          k;
    w = '0;
    for (int j = 0; j < 4; j++) begin
      k = j + 4 * part - off;
      if (k >= 0 && k < n) w[8*j +: 8] = d[8*k +: 8];
    end
    return w;
  endfunction

  // one byte of ones per enabled lane
  function automatic logic [31:0] lane_mask(input logic [3:0] be);
    logic [31:0] m;
    for (int j = 0; j < 4; j++) m[8*j +: 8] = {8{be[j]}};
    return m;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h got %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // bus monitor and timeout
  ////////////////////

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > Timeout) begin
      $display("timeout, the run did not finish within %0d cycles", Timeout);
      $display("Test failures found");
      $fatal(1);
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && data_req && data_gnt) begin
      gnt_addr[gnt_total % 1024]  = data_addr;
      gnt_be[gnt_total % 1024]    = data_be;
      gnt_we[gnt_total % 1024]    = data_we;
      gnt_wdata[gnt_total % 1024] = data_wdata;
      gnt_total = gnt_total + 1;
    end
    if (rst_ni && data_rvalid) rv_total = rv_total + 1;
  end

  ////////////////////
  // one access from request to response
  ////////////////////

  task automatic run_op();
    logic [31:0] base, a0, a1, exp_last;
    lsu_word_u   exp;
    int          n, off, g0, r0;
    logic        split, err;
    seed = lcg_next(seed);
    base = {24'h0, seed[23:16]};
    lsu_type = lsu_type_e'(seed[11:10]);
    sign_ext = seed[12];
    lsu_we   = seed[13];
    seed     = lcg_next(seed);
    wdata    = seed;
    n     = (lsu_type == LSU_WORD) ? 4 : (lsu_type == LSU_HALF) ? 2 : 1;
    off   = int'(base[1:0]);
    a0    = {base[31:2], 2'b00};
    a1    = a0 + 32'd4;
    split = (off + n > 4);
    err   = (a0[7:6] == 2'b11) || (split && a1[7:6] == 2'b11);
    exp_last = (split && a0[7:6] != 2'b11) ? a1 : base;
    exp = '0;
    for (int k = 0; k < n; k++) exp.b[k] = model[(base + k) & 255];
    if (sign_ext && n == 2) exp.h[1] = {16{exp.b[1][7]}};
    if (sign_ext && n == 1) exp = {{24{exp.b[0][7]}}, exp.b[0]};
    if (lsu_we) begin
      for (int k = 0; k < n; k++) model[(base + k) & 255] = wdata[8*k +: 8];
    end
    g0 = gnt_total;
    r0 = rv_total;
    addr    = base;
    lsu_req = 1'b1;
    @(negedge clk_i);
    lsu_req = 1'b0;
    while (!resp_valid) begin
      if (split && (gnt_total - g0 >= 1) && !((gnt_total - g0 == 2) && (rv_total - r0 >= 1)))
        check("busy_o", 32'd1, {31'd0, busy});
      addr = incr_req ? a1 : base;
      @(negedge clk_i);
    end
    check("lsu_rdata_valid_o", {31'd0, !lsu_we && !err}, {31'd0, rdata_valid});
    check("load_err_o", {31'd0, !lsu_we && err}, {31'd0, load_err});
    check("store_err_o", {31'd0, lsu_we && err}, {31'd0, store_err});
    if (!lsu_we && !err) check("lsu_rdata_o", exp, rdata);
    @(negedge clk_i);
    check("lsu_resp_valid_o", 32'd0, {31'd0, resp_valid});
    check("lsu_rdata_valid_o", 32'd0, {31'd0, rdata_valid});
    check("grant count", split ? 32'd2 : 32'd1, gnt_total - g0);
    check("rvalid count", gnt_total - g0, rv_total - r0);
    for (int p = 0; p < (split ? 2 : 1); p++) begin
      check("data_addr_o", p == 0 ? a0 : a1, gnt_addr[(g0 + p) % 1024]);
      check("data_be_o", {28'd0, expect_be(off, n, p)}, {28'd0, gnt_be[(g0 + p) % 1024]});
      check("data_we_o", {31'd0, lsu_we}, {31'd0, gnt_we[(g0 + p) % 1024]});
      if (lsu_we)
        check("data_wdata_o", expect_lanes(wdata, off, n, p),
              gnt_wdata[(g0 + p) % 1024] & lane_mask(expect_be(off, n, p)));
    end
    check("addr_last_o", exp_last, addr_last);
  endtask

  initial begin
    cycles    = 0;
    gnt_total = 0;
    rv_total  = 0;
    seed      = 32'h42b7;
    rst_ni    = 1'b0;
    lsu_req   = 1'b0;
    lsu_we    = 1'b0;
    lsu_type  = LSU_WORD;
    sign_ext  = 1'b0;
    wdata     = '0;
    addr      = '0;
    for (int i = 0; i < 256; i++) model[i] = 8'(u_mem.fill_word(i / 4) >> (8 * (i % 4)));
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // idle outputs before any request
    check("busy_o", 32'd0, {31'd0, busy});
    check("data_req_o", 32'd0, {31'd0, data_req});
    check("strobes", 32'd0, {27'd0, resp_valid, rdata_valid, load_err, store_err, incr_req});
    check("addr_last_o", 32'd0, addr_last);
    for (int op = 0; op < NumOps; op++) run_op();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: all.f
design/lsu_pkg.sv
design/lsu_store_align.sv
design/lsu_load_align.sv
design/lsu_ctrl_fsm.sv
design/lsu_top.sv
bench/lsu_mem_slave.sv
bench/lsu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module lsu_tb -o lsu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed"
  exit $status
fi

./obj_dir/lsu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0
